/* riscv_consts.svh */
`ifndef RISCV_CONSTS_SVH
`define RISCV_CONSTS_SVH

// machine word and register file size
`define XLEN     32
`define NUM_REGS 32

// first fetch address after reset
`define RESET_PC 32'h0000_0000

// byte distance between consecutive instructions
`define INSTR_ALIGN 4

`endif

/* rv_isa_pkg.sv */
`include "riscv_consts.svh"

package rv_isa_pkg;

   typedef logic [$clog2(`NUM_REGS)-1:0] reg_idx_t;

   // major opcodes of the supported subset
   typedef enum logic [6:0] {
      OP     = 7'b0110011,
      OP_IMM = 7'b0010011,
      LOAD   = 7'b0000011,
      STORE  = 7'b0100011,
      BRANCH = 7'b1100011,
      JAL    = 7'b1101111,
      JALR   = 7'b1100111,
      LUI    = 7'b0110111,
      AUIPC  = 7'b0010111
   } opcode_e;

   // funct3 of OP and OP-IMM
   localparam logic [2:0] F3_ADD_SUB = 3'b000;
   localparam logic [2:0] F3_SLL     = 3'b001;
   localparam logic [2:0] F3_SLT     = 3'b010;
   localparam logic [2:0] F3_SLTU    = 3'b011;
   localparam logic [2:0] F3_XOR     = 3'b100;
   localparam logic [2:0] F3_SRL_SRA = 3'b101;
   localparam logic [2:0] F3_OR      = 3'b110;

   // funct3 of the conditional branches
   localparam logic [2:0] F3_BEQ  = 3'b000;
   localparam logic [2:0] F3_BNE  = 3'b001;
   localparam logic [2:0] F3_BLT  = 3'b100;
   localparam logic [2:0] F3_BGE  = 3'b101;
   localparam logic [2:0] F3_BLTU = 3'b110;
   localparam logic [2:0] F3_BGEU = 3'b111;

   // selects SUB over ADD and SRA over SRL
   localparam logic [6:0] F7_ALT = 7'b0100000;

   typedef struct packed {
      logic [6:0] funct7;
      reg_idx_t   rs2;
      reg_idx_t   rs1;
      logic [2:0] funct3;
      reg_idx_t   rd;
      logic [6:0] opcode;
   } r_fmt_t;

   typedef struct packed {
      logic [11:0] imm;
      reg_idx_t    rs1;
      logic [2:0]  funct3;
      reg_idx_t    rd;
      logic [6:0]  opcode;
   } i_fmt_t;

   typedef struct packed {
      logic [6:0] imm_hi;
      reg_idx_t   rs2;
      reg_idx_t   rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
   } s_fmt_t;

   // branch offset is scrambled across the word
   typedef struct packed {
      logic       imm_12;
      logic [5:0] imm_10_5;
      reg_idx_t   rs2;
      reg_idx_t   rs1;
      logic [2:0] funct3;
      logic [3:0] imm_4_1;
      logic       imm_11;
      logic [6:0] opcode;
   } b_fmt_t;

   typedef struct packed {
      logic [19:0] imm_31_12;
      reg_idx_t    rd;
      logic [6:0]  opcode;
   } u_fmt_t;

   typedef struct packed {
      logic       imm_20;
      logic [9:0] imm_10_1;
      logic       imm_11;
      logic [7:0] imm_19_12;
      reg_idx_t   rd;
      logic [6:0] opcode;
   } j_fmt_t;

   // one instruction word, viewed in every base format
   typedef union packed {
      r_fmt_t r;
      i_fmt_t i;
      s_fmt_t s;
      b_fmt_t b;
      u_fmt_t u;
      j_fmt_t j;
   } rv_instr_u;

endpackage

/* rv_pipe_pkg.sv */
package rv_pipe_pkg;

   typedef enum logic [3:0] {
      ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND, PASS_B
   } alu_op_e;

   // NONE must stay first, a cleared ctrl word never branches
   typedef enum logic [2:0] {
      NONE, EQ, NE, LT, GE, LTU, GEU, JUMP
   } br_op_e;

   // operand source chosen for the execute stage
   localparam logic [1:0] FWD_NONE = 2'd0;
   localparam logic [1:0] FWD_MEM  = 2'd1;
   localparam logic [1:0] FWD_WB   = 2'd2;

   typedef struct packed {
      logic                 valid;
      alu_op_e              alu_op;
      br_op_e               br_op;
      logic                 use_imm;
      logic                 use_pc;
      logic                 indirect;
      logic                 mem_read;
      logic                 mem_write;
      logic                 reg_write;
      rv_isa_pkg::reg_idx_t rd;
      rv_isa_pkg::reg_idx_t rs1;
      rv_isa_pkg::reg_idx_t rs2;
   } ctrl_t;

endpackage

/* exec_if.sv */
`timescale 1ns/10ps
`include "riscv_consts.svh"

// execute stage inputs, operands already forwarded
interface exec_if;
   import rv_pipe_pkg::*;

   ctrl_t            ctrl;
   logic [`XLEN-1:0] pc;
   logic [`XLEN-1:0] operand_a;
   logic [`XLEN-1:0] operand_b;
   logic [`XLEN-1:0] imm;

   modport core   (output ctrl, pc, operand_a, operand_b, imm);
   modport alu    (input ctrl, pc, operand_a, operand_b, imm);
   modport branch (input ctrl, pc, operand_a, operand_b, imm);

endinterface

/* rv_decoder.sv */
`timescale 1ns/10ps
`include "riscv_consts.svh"

module rv_decoder (
   input  rv_isa_pkg::rv_instr_u instr_i,
   output rv_pipe_pkg::ctrl_t    ctrl_o,
   output logic [`XLEN-1:0]      imm_o
);
   import rv_isa_pkg::*;
   import rv_pipe_pkg::*;

   logic [`XLEN-1:0] i_imm;
   logic [`XLEN-1:0] s_imm;
   logic [`XLEN-1:0] b_imm;
   logic [`XLEN-1:0] u_imm;
   logic [`XLEN-1:0] j_imm;
   logic [2:0]       funct3;
   logic             alt;

   function automatic alu_op_e alu_op_of(input logic [2:0] f3, input logic sub_sra);
      case (f3)
         F3_ADD_SUB: return sub_sra ? SUB : ADD;
         F3_SLL:     return SLL;
         F3_SLT:     return SLT;
         F3_SLTU:    return SLTU;
         F3_XOR:     return XOR;
         F3_SRL_SRA: return sub_sra ? SRA : SRL;
         F3_OR:      return OR;
         default:    return AND;
      endcase
   endfunction

   function automatic br_op_e br_op_of(input logic [2:0] f3);
      case (f3)
         F3_BEQ:  return EQ;
         F3_BNE:  return NE;
         F3_BLT:  return LT;
         F3_BGE:  return GE;
         F3_BLTU: return LTU;
         F3_BGEU: return GEU;
         default: return NONE;
      endcase
   endfunction

   assign funct3 = instr_i.r.funct3;
   assign alt    = instr_i.r.funct7 == F7_ALT;

   // sign-extended immediates, one per format
   assign i_imm = {{(`XLEN-12){instr_i.i.imm[11]}}, instr_i.i.imm};
   assign s_imm = {{(`XLEN-12){instr_i.s.imm_hi[6]}}, instr_i.s.imm_hi, instr_i.s.imm_lo};
   assign b_imm = {{(`XLEN-12){instr_i.b.imm_12}}, instr_i.b.imm_11,
                   instr_i.b.imm_10_5, instr_i.b.imm_4_1, 1'b0};
   assign u_imm = {instr_i.u.imm_31_12, 12'b0};
   assign j_imm = {{(`XLEN-20){instr_i.j.imm_20}}, instr_i.j.imm_19_12,
                   instr_i.j.imm_11, instr_i.j.imm_10_1, 1'b0};

   always_comb begin
      ctrl_o     = '0;
      ctrl_o.rd  = instr_i.r.rd;
      ctrl_o.rs1 = instr_i.r.rs1;
      ctrl_o.rs2 = instr_i.r.rs2;
      imm_o      = i_imm;
      case (instr_i.r.opcode)
         OP: begin
            ctrl_o.valid     = 1'b1;
            ctrl_o.reg_write = 1'b1;
            ctrl_o.alu_op    = alu_op_of(funct3, alt);
         end
         OP_IMM: begin
            ctrl_o.valid     = 1'b1;
            ctrl_o.reg_write = 1'b1;
            ctrl_o.use_imm   = 1'b1;
            // upper imm bits only mean SRAI on a right shift
            ctrl_o.alu_op    = alu_op_of(funct3, alt && funct3 == F3_SRL_SRA);
         end
         LOAD: begin
            ctrl_o.valid     = 1'b1;
            ctrl_o.reg_write = 1'b1;
            ctrl_o.use_imm   = 1'b1;
            ctrl_o.mem_read  = 1'b1;
         end
         STORE: begin
            ctrl_o.valid     = 1'b1;
            ctrl_o.use_imm   = 1'b1;
            ctrl_o.mem_write = 1'b1;
            imm_o            = s_imm;
         end
         BRANCH: begin
            ctrl_o.br_op = br_op_of(funct3);
            ctrl_o.valid = ctrl_o.br_op != NONE;
            imm_o        = b_imm;
         end
         JAL: begin
            ctrl_o.valid     = 1'b1;
            ctrl_o.reg_write = 1'b1;
            ctrl_o.br_op     = JUMP;
            imm_o            = j_imm;
         end
         JALR: begin
            ctrl_o.valid     = 1'b1;
            ctrl_o.reg_write = 1'b1;
            ctrl_o.br_op     = JUMP;
            ctrl_o.indirect  = 1'b1;
         end
         LUI: begin
            ctrl_o.valid     = 1'b1;
            ctrl_o.reg_write = 1'b1;
            ctrl_o.use_imm   = 1'b1;
            ctrl_o.alu_op    = PASS_B;
            imm_o            = u_imm;
         end
         AUIPC: begin
            ctrl_o.valid     = 1'b1;
            ctrl_o.reg_write = 1'b1;
            ctrl_o.use_imm   = 1'b1;
            ctrl_o.use_pc    = 1'b1;
            imm_o            = u_imm;
         end
         default: ;
      endcase
   end

endmodule

/* rv_regfile.sv */
`timescale 1ns/10ps
`include "riscv_consts.svh"

module rv_regfile (
   input  logic                 clk,
   input  logic                 reset,
   input  rv_isa_pkg::reg_idx_t rs1_i,
   input  rv_isa_pkg::reg_idx_t rs2_i,
   input  rv_isa_pkg::reg_idx_t rd_i,
   input  logic                 we_i,
   input  logic [`XLEN-1:0]     wdata_i,
   output logic [`XLEN-1:0]     rdata1_o,
   output logic [`XLEN-1:0]     rdata2_o
);
   import rv_isa_pkg::*;

   logic [`XLEN-1:0] regs [`NUM_REGS];

   // x0 reads zero, a same-cycle write is passed straight through
   function automatic logic [`XLEN-1:0] read_port(input reg_idx_t idx);
      if (idx == '0) begin
         return '0;
      end
      if (we_i && idx == rd_i) begin
         return wdata_i;
      end
      return regs[idx];
   endfunction

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < `NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (we_i && rd_i != '0) begin
         regs[rd_i] <= wdata_i;
      end
   end

   always_comb begin
      rdata1_o = read_port(rs1_i);
      rdata2_o = read_port(rs2_i);
   end

endmodule

/* rv_alu.sv */
`timescale 1ns/10ps
`include "riscv_consts.svh"

module rv_alu (
   exec_if.alu              ex,
   output logic [`XLEN-1:0] result_o
);
   import rv_pipe_pkg::*;

   logic [`XLEN-1:0]         op_a;
   logic [`XLEN-1:0]         op_b;
   logic [$clog2(`XLEN)-1:0] shamt;

   // pc only for AUIPC, immediate for OP-IMM, loads, stores and LUI
   assign op_a  = ex.ctrl.use_pc ? ex.pc : ex.operand_a;
   assign op_b  = ex.ctrl.use_imm ? ex.imm : ex.operand_b;
   assign shamt = op_b[$clog2(`XLEN)-1:0];

   always_comb begin
      case (ex.ctrl.alu_op)
         ADD:     result_o = op_a + op_b;
         SUB:     result_o = op_a - op_b;
         SLL:     result_o = op_a << shamt;
         SLT:     result_o = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
         SLTU:    result_o = {{(`XLEN-1){1'b0}}, op_a < op_b};
         XOR:     result_o = op_a ^ op_b;
         SRL:     result_o = op_a >> shamt;
         SRA:     result_o = $unsigned($signed(op_a) >>> shamt);
         OR:      result_o = op_a | op_b;
         AND:     result_o = op_a & op_b;
         PASS_B:  result_o = op_b;
         default: result_o = '0;
      endcase
   end

endmodule

/* rv_branch_unit.sv */
`timescale 1ns/10ps
`include "riscv_consts.svh"

module rv_branch_unit (
   exec_if.branch           ex,
   output logic             taken_o,
   output logic [`XLEN-1:0] target_o,
   output logic [`XLEN-1:0] link_o
);
   import rv_pipe_pkg::*;

   logic             eq;
   logic             lt;
   logic             ltu;
   logic             cond;
   logic [`XLEN-1:0] sum;

   assign eq  = ex.operand_a == ex.operand_b;
   assign lt  = $signed(ex.operand_a) < $signed(ex.operand_b);
   assign ltu = ex.operand_a < ex.operand_b;

   always_comb begin
      case (ex.ctrl.br_op)
         EQ:      cond = eq;
         NE:      cond = !eq;
         LT:      cond = lt;
         GE:      cond = !lt;
         LTU:     cond = ltu;
         GEU:     cond = !ltu;
         JUMP:    cond = 1'b1;
         default: cond = 1'b0;
      endcase
   end

   assign taken_o = ex.ctrl.valid && cond;

   // JALR is relative to rs1 and drops bit 0
   assign sum      = (ex.ctrl.indirect ? ex.operand_a : ex.pc) + ex.imm;
   assign target_o = {sum[`XLEN-1:1], sum[0] & !ex.ctrl.indirect};
   assign link_o   = ex.pc + `INSTR_ALIGN;

endmodule

/* rv_hazard.sv */
`timescale 1ns/10ps

module rv_hazard (
   input  rv_isa_pkg::reg_idx_t ex_rs1_i,
   input  rv_isa_pkg::reg_idx_t ex_rs2_i,
   input  rv_isa_pkg::reg_idx_t mem_rd_i,
   input  rv_isa_pkg::reg_idx_t wb_rd_i,
   input  logic                 mem_wr_i,
   input  logic                 wb_wr_i,
   input  logic                 ex_taken_i,
   output logic [1:0]           fwd_a_o,
   output logic [1:0]           fwd_b_o,
   output logic                 flush_o
);
   import rv_isa_pkg::*;
   import rv_pipe_pkg::*;

   // the younger producer in memory wins over writeback
   function automatic logic [1:0] fwd_sel(input reg_idx_t rs, input reg_idx_t mem_rd,
                                          input logic mem_wr, input reg_idx_t wb_rd,
                                          input logic wb_wr);
      if (rs == '0) begin
         return FWD_NONE;
      end
      if (mem_wr && mem_rd == rs) begin
         return FWD_MEM;
      end
      if (wb_wr && wb_rd == rs) begin
         return FWD_WB;
      end
      return FWD_NONE;
   endfunction

   assign fwd_a_o = fwd_sel(ex_rs1_i, mem_rd_i, mem_wr_i, wb_rd_i, wb_wr_i);
   assign fwd_b_o = fwd_sel(ex_rs2_i, mem_rd_i, mem_wr_i, wb_rd_i, wb_wr_i);

   // squash fetch and decode behind a taken transfer
   assign flush_o = ex_taken_i;

endmodule

/* rv_core.sv */
`timescale 1ns/10ps
`include "riscv_consts.svh"

module rv_core (
   input  logic                 clk,
   input  logic                 reset,
   output logic [`XLEN-1:0]     imem_addr_o,
   input  logic [`XLEN-1:0]     imem_data_i,
   output logic [`XLEN-1:0]     dmem_addr_o,
   output logic [`XLEN-1:0]     dmem_wdata_o,
   output logic                 dmem_we_o,
   input  logic [`XLEN-1:0]     dmem_rdata_i,
   output logic                 retire_valid_o,
   output logic [`XLEN-1:0]     retire_pc_o,
   output logic                 retire_we_o,
   output rv_isa_pkg::reg_idx_t retire_rd_o,
   output logic [`XLEN-1:0]     retire_data_o
);
   import rv_isa_pkg::*;
   import rv_pipe_pkg::*;

   typedef struct packed {
      logic             valid;
      logic [`XLEN-1:0] pc;
      rv_instr_u        instr;
   } if_id_t;

   typedef struct packed {
      ctrl_t            ctrl;
      logic [`XLEN-1:0] pc;
      logic [`XLEN-1:0] rs1_data;
      logic [`XLEN-1:0] rs2_data;
      logic [`XLEN-1:0] imm;
   } id_ex_t;

   typedef struct packed {
      ctrl_t            ctrl;
      logic [`XLEN-1:0] pc;
      logic [`XLEN-1:0] result;
      logic [`XLEN-1:0] store_data;
   } ex_mem_t;

   typedef struct packed {
      ctrl_t            ctrl;
      logic [`XLEN-1:0] pc;
      logic [`XLEN-1:0] data;
   } mem_wb_t;

   logic [`XLEN-1:0] pc_q;
   if_id_t           if_id_q;
   id_ex_t           id_ex_q;
   ex_mem_t          ex_mem_q;
   mem_wb_t          mem_wb_q;

   ctrl_t            dec_ctrl;
   ctrl_t            id_ctrl;
   logic [`XLEN-1:0] dec_imm;
   logic [`XLEN-1:0] rf_rdata1;
   logic [`XLEN-1:0] rf_rdata2;

   logic [1:0]       fwd_a;
   logic [1:0]       fwd_b;
   logic             flush;
   logic [`XLEN-1:0] alu_result;
   logic             br_taken;
   logic [`XLEN-1:0] br_target;
   logic [`XLEN-1:0] br_link;
   logic [`XLEN-1:0] ex_result;

   logic [`XLEN-1:0] mem_result;
   logic             mem_wr;
   logic             wb_wr;

   exec_if ex_bus ();

   function automatic logic [`XLEN-1:0] pick(input logic [1:0] sel,
                                             input logic [`XLEN-1:0] from_reg,
                                             input logic [`XLEN-1:0] from_mem,
                                             input logic [`XLEN-1:0] from_wb);
      case (sel)
         FWD_MEM: return from_mem;
         FWD_WB:  return from_wb;
         default: return from_reg;
      endcase
   endfunction

   // decode and register read
   rv_decoder u_decoder (
      .instr_i (if_id_q.instr),
      .ctrl_o  (dec_ctrl),
      .imm_o   (dec_imm)
   );

   rv_regfile u_regfile (
      .clk      (clk),
      .reset    (reset),
      .rs1_i    (dec_ctrl.rs1),
      .rs2_i    (dec_ctrl.rs2),
      .rd_i     (mem_wb_q.ctrl.rd),
      .we_i     (wb_wr),
      .wdata_i  (mem_wb_q.data),
      .rdata1_o (rf_rdata1),
      .rdata2_o (rf_rdata2)
   );

   always_comb begin
      id_ctrl       = dec_ctrl;
      id_ctrl.valid = dec_ctrl.valid && if_id_q.valid;
   end

   // execute, both units see the same forwarded operands
   assign ex_bus.ctrl      = id_ex_q.ctrl;
   assign ex_bus.pc        = id_ex_q.pc;
   assign ex_bus.imm       = id_ex_q.imm;
   assign ex_bus.operand_a = pick(fwd_a, id_ex_q.rs1_data, mem_result, mem_wb_q.data);
   assign ex_bus.operand_b = pick(fwd_b, id_ex_q.rs2_data, mem_result, mem_wb_q.data);

   rv_alu u_alu (
      .ex       (ex_bus.alu),
      .result_o (alu_result)
   );

   rv_branch_unit u_branch (
      .ex       (ex_bus.branch),
      .taken_o  (br_taken),
      .target_o (br_target),
      .link_o   (br_link)
   );

   // jumps write the return address
   assign ex_result = (id_ex_q.ctrl.br_op == JUMP) ? br_link : alu_result;

   rv_hazard u_hazard (
      .ex_rs1_i   (id_ex_q.ctrl.rs1),
      .ex_rs2_i   (id_ex_q.ctrl.rs2),
      .mem_rd_i   (ex_mem_q.ctrl.rd),
      .wb_rd_i    (mem_wb_q.ctrl.rd),
      .mem_wr_i   (mem_wr),
      .wb_wr_i    (wb_wr),
      .ex_taken_i (br_taken),
      .fwd_a_o    (fwd_a),
      .fwd_b_o    (fwd_b),
      .flush_o    (flush)
   );

   // memory stage, load data is usable in the same cycle
   assign mem_result   = ex_mem_q.ctrl.mem_read ? dmem_rdata_i : ex_mem_q.result;
   assign mem_wr       = ex_mem_q.ctrl.valid && ex_mem_q.ctrl.reg_write;
   assign wb_wr        = mem_wb_q.ctrl.valid && mem_wb_q.ctrl.reg_write;

   assign imem_addr_o  = pc_q;
   assign dmem_addr_o  = ex_mem_q.result;
   assign dmem_wdata_o = ex_mem_q.store_data;
   assign dmem_we_o    = ex_mem_q.ctrl.valid && ex_mem_q.ctrl.mem_write;

   always_ff @(posedge clk) begin
      if (reset) begin
         pc_q     <= `RESET_PC;
         if_id_q  <= '0;
         id_ex_q  <= '0;
         ex_mem_q <= '0;
         mem_wb_q <= '0;
      end else begin
         if (flush) begin
            // redirect and drop the two younger instructions
            pc_q    <= br_target;
            if_id_q <= '0;
            id_ex_q <= '0;
         end else begin
            pc_q             <= pc_q + `INSTR_ALIGN;
            if_id_q.valid    <= 1'b1;
            if_id_q.pc       <= pc_q;
            if_id_q.instr    <= imem_data_i;
            id_ex_q.ctrl     <= id_ctrl;
            id_ex_q.pc       <= if_id_q.pc;
            id_ex_q.rs1_data <= rf_rdata1;
            id_ex_q.rs2_data <= rf_rdata2;
            id_ex_q.imm      <= dec_imm;
         end
         ex_mem_q.ctrl       <= id_ex_q.ctrl;
         ex_mem_q.pc         <= id_ex_q.pc;
         ex_mem_q.result     <= ex_result;
         ex_mem_q.store_data <= ex_bus.operand_b;
         mem_wb_q.ctrl       <= ex_mem_q.ctrl;
         mem_wb_q.pc         <= ex_mem_q.pc;
         mem_wb_q.data       <= mem_result;
      end
   end

   // retire straight from the writeback register
   assign retire_valid_o = mem_wb_q.ctrl.valid;
   assign retire_pc_o    = mem_wb_q.pc;
   assign retire_we_o    = wb_wr && mem_wb_q.ctrl.rd != '0;
   assign retire_rd_o    = mem_wb_q.ctrl.rd;
   assign retire_data_o  = mem_wb_q.data;

endmodule

/* tb_rv_core.sv */
`timescale 1ns/10ps
`include "riscv_consts.svh"

module tb_rv_core;
   import rv_isa_pkg::*;

   localparam int PROG_LEN     = 64;
   localparam int END_PC       = PROG_LEN * 4;
   localparam int IMEM_WORDS   = 256;
   localparam int DMEM_WORDS   = 256;
   localparam int MAX_STEPS    = 128;
   localparam int RESET_CYCLES = 4;
   // a taken transfer costs three cycles, plus pipeline fill
   localparam int WATCHDOG_CYCLES = 8 * (PROG_LEN + 1) + 50;
   localparam logic [31:0] SEED = 32'h1f63d93d;

   logic             clk;
   logic             reset;
   logic [`XLEN-1:0] imem_addr_o;
   logic [`XLEN-1:0] imem_data_i;
   logic [`XLEN-1:0] dmem_addr_o;
   logic [`XLEN-1:0] dmem_wdata_o;
   logic             dmem_we_o;
   logic [`XLEN-1:0] dmem_rdata_i;
   logic             retire_valid_o;
   logic [`XLEN-1:0] retire_pc_o;
   logic             retire_we_o;
   logic [4:0]       retire_rd_o;
   logic [`XLEN-1:0] retire_data_o;

   logic [31:0] imem [IMEM_WORDS];
   logic [31:0] dmem [DMEM_WORDS];
   logic [31:0] model_mem [DMEM_WORDS];
   logic [31:0] model_regs [32];

   // architectural trace, one entry per executed instruction
   logic [31:0] exp_pc [MAX_STEPS];
   logic        exp_we [MAX_STEPS];
   logic [4:0]  exp_rd [MAX_STEPS];
   logic [31:0] exp_data [MAX_STEPS];
   logic [31:0] exp_st_addr [MAX_STEPS];
   logic [31:0] exp_st_data [MAX_STEPS];
   int          exp_count;
   int          exp_st_count;

   int retired;
   int stores_seen;
   int value_errors;
   int other_errors;

   rv_core uut (
      .clk            (clk),
      .reset          (reset),
      .imem_addr_o    (imem_addr_o),
      .imem_data_i    (imem_data_i),
      .dmem_addr_o    (dmem_addr_o),
      .dmem_wdata_o   (dmem_wdata_o),
      .dmem_we_o      (dmem_we_o),
      .dmem_rdata_i   (dmem_rdata_i),
      .retire_valid_o (retire_valid_o),
      .retire_pc_o    (retire_pc_o),
      .retire_we_o    (retire_we_o),
      .retire_rd_o    (retire_rd_o),
      .retire_data_o  (retire_data_o)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   function automatic logic [31:0] fill_word(input int idx);
      return (32'(idx) * 32'h9e37_79b9) ^ 32'h5a5a_0000;
   endfunction

   function automatic logic [4:0] rand_reg();
      return 5'($urandom_range(0, 7));
   endfunction

   function automatic logic [11:0] word_offset();
      return 12'(4 * $urandom_range(0, 15));
   endfunction

   function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
      return {imm, rs1, f3, rd, op};
   endfunction

   function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
      return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], STORE};
   endfunction

   function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
      return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], BRANCH};
   endfunction

   function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
      return {off[20], off[10:1], off[11], off[19:12], rd, JAL};
   endfunction

   // reference arithmetic of OP and OP-IMM by funct3
   function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
      case (f3)
         3'd0:    return alt ? a - b : a + b;
         3'd1:    return a << b[4:0];
         3'd2:    return {31'b0, $signed(a) < $signed(b)};
         3'd3:    return {31'b0, a < b};
         3'd4:    return a ^ b;
         3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
         3'd6:    return a | b;
         default: return a & b;
      endcase
   endfunction

   function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                         input logic [31:0] b);
      case (f3)
         3'd0:    return a == b;
         3'd1:    return a != b;
         3'd4:    return $signed(a) < $signed(b);
         3'd5:    return $signed(a) >= $signed(b);
         3'd6:    return a < b;
         3'd7:    return a >= b;
         default: return 1'b0;
      endcase
   endfunction

   task automatic gen_program();
      int          cls;
      logic [4:0]  rd;
      logic [4:0]  rs1;
      logic [4:0]  rs2;
      logic [2:0]  f3;
      logic [2:0]  br_idx;
      logic [6:0]  f7;
      logic [11:0] imm12;
      logic [31:0] word;
      // unused words carry an unknown opcode
      for (int k = 0; k < IMEM_WORDS; k++) begin
         imem[k] = {25'(k), 7'h7f};
      end
      for (int i = 0; i < PROG_LEN; i++) begin
         rd  = rand_reg();
         rs1 = rand_reg();
         rs2 = rand_reg();
         f3  = 3'($urandom_range(0, 7));
         cls = $urandom_range(0, 11);
         case (cls)
            0, 1: begin
               f7 = ((f3 == 3'd0 || f3 == 3'd5) && $urandom_range(0, 1) == 1) ? 7'h20 : 7'h00;
               word = {f7, rs2, rs1, f3, rd, OP};
            end
            2, 3, 4: begin
               imm12 = 12'($urandom);
               if (f3 == 3'd1) begin
                  imm12 = {7'h00, imm12[4:0]};
               end else if (f3 == 3'd5) begin
                  imm12 = {imm12[10] ? 7'h20 : 7'h00, imm12[4:0]};
               end
               word = enc_i(imm12, rs1, f3, rd, OP_IMM);
            end
            5: word = {20'($urandom), rd, LUI};
            6: word = {20'($urandom), rd, AUIPC};
            7: word = enc_i(word_offset(), 5'd0, 3'b010, rd, LOAD);
            8: word = enc_s(word_offset(), rs2, 5'd0);
            9: begin
               // maps 0..5 onto BEQ, BNE, BLT, BGE, BLTU, BGEU
               br_idx = 3'($urandom_range(0, 5));
               f3     = (br_idx < 3'd2) ? br_idx : br_idx + 3'd2;
               word   = enc_b(13'(4 * $urandom_range(1, PROG_LEN - i)), rs2, rs1, f3);
            end
            10: word = enc_j(21'(4 * $urandom_range(1, PROG_LEN - i)), rd);
            default: word = enc_i(12'(4 * $urandom_range(i + 1, PROG_LEN)), 5'd0, 3'd0, rd, JALR);
         endcase
         imem[i] = word;
      end
      // end loop
      imem[PROG_LEN] = enc_j(21'd0, 5'd0);
   endtask

   task automatic run_model();
      logic [31:0] pc;
      logic [31:0] instr;
      logic [31:0] next_pc;
      logic [31:0] rs1v;
      logic [31:0] rs2v;
      logic [31:0] result;
      logic [31:0] addr;
      logic [31:0] imm_i;
      logic [31:0] imm_s;
      logic [31:0] imm_b;
      logic [31:0] imm_u;
      logic [31:0] imm_j;
      logic [4:0]  rd;
      logic [2:0]  f3;
      logic        writes;
      logic        done;
      for (int k = 0; k < 32; k++) begin
         model_regs[k] = '0;
      end
      for (int k = 0; k < DMEM_WORDS; k++) begin
         model_mem[k] = fill_word(k);
      end
      pc           = `RESET_PC;
      exp_count    = 0;
      exp_st_count = 0;
      done         = 1'b0;
      while (!done && exp_count < MAX_STEPS) begin
         instr   = imem[pc[9:2]];
         rd      = instr[11:7];
         f3      = instr[14:12];
         rs1v    = model_regs[instr[19:15]];
         rs2v    = model_regs[instr[24:20]];
         imm_i   = {{20{instr[31]}}, instr[31:20]};
         imm_s   = {{20{instr[31]}}, instr[31:25], instr[11:7]};
         imm_b   = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
         imm_u   = {instr[31:12], 12'b0};
         imm_j   = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
         next_pc = pc + 32'd4;
         writes  = 1'b1;
         result  = '0;
         case (instr[6:0])
            LUI:    result = imm_u;
            AUIPC:  result = pc + imm_u;
            JAL: begin
               result  = pc + 32'd4;
               next_pc = pc + imm_j;
            end
            JALR: begin
               result  = pc + 32'd4;
               next_pc = (rs1v + imm_i) & ~32'h1;
            end
            BRANCH: begin
               writes = 1'b0;
               if (branch_taken(f3, rs1v, rs2v)) begin
                  next_pc = pc + imm_b;
               end
            end
            LOAD: begin
               addr   = rs1v + imm_i;
               result = model_mem[addr[9:2]];
            end
            STORE: begin
               writes                    = 1'b0;
               addr                      = rs1v + imm_s;
               exp_st_addr[exp_st_count] = addr;
               exp_st_data[exp_st_count] = rs2v;
               model_mem[addr[9:2]]      = rs2v;
               exp_st_count++;
            end
            OP_IMM: result = alu_ref(f3, instr[30] && f3 == 3'd5, rs1v, imm_i);
            OP:     result = alu_ref(f3, instr[30], rs1v, rs2v);
            default: writes = 1'b0;
         endcase
         exp_pc[exp_count]   = pc;
         exp_we[exp_count]   = writes && rd != 5'd0;
         exp_rd[exp_count]   = rd;
         exp_data[exp_count] = result;
         if (writes && rd != 5'd0) begin
            model_regs[rd] = result;
         end
         exp_count++;
         done = (pc == END_PC);
         pc   = next_pc;
      end
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
      if (got !== expected) begin
         value_errors++;
         $display("[FAIL] %s: got %h, expected %h at %0t", name, got, expected, $time);
      end
   endtask

   task automatic check_store();
      if (stores_seen >= exp_st_count) begin
         other_errors++;
         $display("a store to %h came after all %0d stores of the model", dmem_addr_o,
                  exp_st_count);
      end else begin
         check_value("dmem_addr_o", dmem_addr_o, exp_st_addr[stores_seen]);
         check_value("dmem_wdata_o", dmem_wdata_o, exp_st_data[stores_seen]);
      end
      stores_seen++;
   endtask

   task automatic check_retire();
      check_value("retire_pc_o", retire_pc_o, exp_pc[retired]);
      check_value("retire_we_o", 32'(retire_we_o), 32'(exp_we[retired]));
      if (exp_we[retired]) begin
         check_value("retire_rd_o", 32'(retire_rd_o), 32'(exp_rd[retired]));
         check_value("retire_data_o", retire_data_o, exp_data[retired]);
      end
      retired++;
   endtask

   // memories answer on the falling edge, stores land on the rising edge
   initial begin : memories
      logic        store_pending;
      logic [31:0] store_addr;
      logic [31:0] store_data;
      store_pending = 1'b0;
      store_addr    = '0;
      store_data    = '0;
      imem_data_i   = '0;
      dmem_rdata_i  = '0;
      for (int k = 0; k < DMEM_WORDS; k++) begin
         dmem[k] = fill_word(k);
      end
      forever begin
         @(posedge clk);
         if (store_pending) begin
            dmem[store_addr[9:2]] = store_data;
         end
         @(negedge clk);
         store_pending = dmem_we_o;
         store_addr    = dmem_addr_o;
         store_data    = dmem_wdata_o;
         imem_data_i   = imem[imem_addr_o[9:2]];
         dmem_rdata_i  = dmem[dmem_addr_o[9:2]];
      end
   end

   initial begin : watchdog
      repeat (RESET_CYCLES + WATCHDOG_CYCLES) @(posedge clk);
      $display("timeout: the program never reached its end loop, %0d of %0d instructions retired",
               retired, exp_count);
      $display("errors: %0d value, %0d other", value_errors, other_errors + 1);
      $display("TB FAILED");
      $finish;
   end

   initial begin : stimulus
      int cycle;
      reset        = 1'b1;
      retired      = 0;
      stores_seen  = 0;
      value_errors = 0;
      other_errors = 0;
      void'($urandom(SEED));
      gen_program();
      run_model();

      repeat (RESET_CYCLES) begin
         @(negedge clk);
         check_value("retire_valid_o", 32'(retire_valid_o), 32'd0);
         check_value("dmem_we_o", 32'(dmem_we_o), 32'd0);
      end
      reset = 1'b0;
      check_value("imem_addr_o", imem_addr_o, `RESET_PC);

      cycle = 0;
      while (retired < exp_count) begin
         @(negedge clk);
         cycle++;
         // pipeline is still empty one edge after reset
         if (cycle == 1) begin
            check_value("retire_valid_o", 32'(retire_valid_o), 32'd0);
            check_value("dmem_we_o", 32'(dmem_we_o), 32'd0);
         end
         if (dmem_we_o) begin
            check_store();
         end
         if (retire_valid_o) begin
            check_retire();
         end
      end
      check_value("store count", stores_seen, exp_st_count);

      $display("errors: %0d value, %0d other, %0d instructions retired in %0d cycles",
               value_errors, other_errors, retired, cycle);
      if (value_errors == 0 && other_errors == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

/* rv_core.f */
+incdir+.
rv_isa_pkg.sv
rv_pipe_pkg.sv
exec_if.sv
rv_decoder.sv
rv_regfile.sv
rv_alu.sv
rv_branch_unit.sv
rv_hazard.sv
rv_core.sv
tb_rv_core.sv

/* Makefile */
TOP = tb_rv_core

sim:
	verilator --binary --timing --top-module $(TOP) -f rv_core.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf obj_dir

.PHONY: sim clean
